// ==== filelist.f ====
rtl/noc_pkg.sv
rtl/hop_if.sv
rtl/lookahead_input_stage.sv
rtl/next_router_predictor.sv
rtl/xy_lookahead_router.sv
rtl/lookahead_routing_top.sv
test/tb_lookahead_routing.sv

// ==== rtl/hop_if.sv ====
`timescale 1ns/1ps

// one in-flight item between two pipeline stages
interface hop_if;

    logic                  valid;
    noc_pkg::x_addr_t      dest_x;
    noc_pkg::y_addr_t      dest_y;
    noc_pkg::x_addr_t      hop_x;    // router address at this stage
    noc_pkg::y_addr_t      hop_y;
    noc_pkg::port_onehot_t hop_port;

    modport src (
        output valid, dest_x, dest_y,
        output hop_x, hop_y, hop_port
    );

    modport dst (
        input valid, dest_x, dest_y,
        input hop_x, hop_y, hop_port
    );

endinterface

// ==== rtl/lookahead_input_stage.sv ====
`timescale 1ns/1ps

module lookahead_input_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  noc_pkg::x_addr_t   cur_x,
    input  noc_pkg::y_addr_t   cur_y,
    input  noc_pkg::x_addr_t   dest_x,
    input  noc_pkg::y_addr_t   dest_y,
    input  noc_pkg::port_enc_t in_port,
    hop_if.src                 hop
);

    noc_pkg::port_onehot_t port_oh;

    // x/y/a/b code to one-hot
    always_comb begin
        port_oh = '0;
        case ({in_port.a, in_port.b})
            noc_pkg::AB_LOCAL: port_oh[noc_pkg::LOCAL] = 1'b1;
            noc_pkg::AB_X: begin
                port_oh[noc_pkg::EAST] = in_port.x;
                port_oh[noc_pkg::WEST] = ~in_port.x;
            end
            noc_pkg::AB_Y: begin
                port_oh[noc_pkg::NORTH] = in_port.y;
                port_oh[noc_pkg::SOUTH] = ~in_port.y;
            end
            default: port_oh = '0; // ab = 11, not a single port
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hop.valid <= 1'b0;
        end else begin
            hop.valid <= in_valid;
        end
    end

    // payload, only meaningful with valid
    always_ff @(posedge clk) begin
        hop.dest_x   <= dest_x;
        hop.dest_y   <= dest_y;
        hop.hop_x    <= cur_x;   // still the current router here
        hop.hop_y    <= cur_y;
        hop.hop_port <= port_oh;
    end

    // deterministic routing never asks for both dimensions at once
    a_in_port_legal: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> !(in_port.a && in_port.b)
    ) else $error("in_port with ab = 11 at %0t", $time);

endmodule

// ==== rtl/lookahead_routing_top.sv ====
`timescale 1ns/1ps

module lookahead_routing_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  noc_pkg::x_addr_t   cur_x,
    input  noc_pkg::y_addr_t   cur_y,
    input  noc_pkg::x_addr_t   dest_x,
    input  noc_pkg::y_addr_t   dest_y,
    input  noc_pkg::port_enc_t in_port,
    output logic               out_valid,
    output noc_pkg::port_enc_t out_port
);

    hop_if hop_a ();   // current router, decoded port
    hop_if hop_b ();   // neighbour router

    lookahead_input_stage u_input (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .cur_x    (cur_x),
        .cur_y    (cur_y),
        .dest_x   (dest_x),
        .dest_y   (dest_y),
        .in_port  (in_port),
        .hop      (hop_a.src)
    );

    next_router_predictor u_predict (
        .clk   (clk),
        .reset (reset),
        .up    (hop_a.dst),
        .down  (hop_b.src)
    );

    xy_lookahead_router u_route (
        .clk       (clk),
        .reset     (reset),
        .up        (hop_b.dst),
        .out_valid (out_valid),
        .out_port  (out_port)
    );

endmodule

// ==== rtl/next_router_predictor.sv ====
`timescale 1ns/1ps

module next_router_predictor (
    input  logic clk,
    input  logic reset,
    hop_if.dst   up,
    hop_if.src   down
);

    noc_pkg::x_addr_t next_x;
    noc_pkg::y_addr_t next_y;

    // neighbour on the chosen port, mesh so no wrap
    always_comb begin
        next_x = up.hop_x;
        next_y = up.hop_y;
        if (up.hop_port[noc_pkg::EAST]) begin
            next_x = up.hop_x + 1'b1;
        end else if (up.hop_port[noc_pkg::NORTH]) begin
            next_y = up.hop_y - 1'b1;
        end else if (up.hop_port[noc_pkg::WEST]) begin
            next_x = up.hop_x - 1'b1;
        end else if (up.hop_port[noc_pkg::SOUTH]) begin
            next_y = up.hop_y + 1'b1;
        end
        // local keeps the current router
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        down.dest_x   <= up.dest_x;
        down.dest_y   <= up.dest_y;
        down.hop_x    <= next_x;
        down.hop_y    <= next_y;
        down.hop_port <= up.hop_port; // for the arrival check downstream
    end

    // decoder upstream must hand over exactly one port
    a_port_onehot: assert property (
        @(posedge clk) disable iff (reset)
        up.valid |-> $onehot(up.hop_port)
    ) else $error("hop_port not one-hot at %0t", $time);

    // a move off the mesh edge means the previous router routed wrongly
    a_stay_in_mesh: assert property (
        @(posedge clk) disable iff (reset)
        up.valid |-> !((up.hop_port[noc_pkg::EAST]  && up.hop_x == noc_pkg::X_LAST) ||
                       (up.hop_port[noc_pkg::NORTH] && up.hop_y == '0) ||
                       (up.hop_port[noc_pkg::WEST]  && up.hop_x == '0) ||
                       (up.hop_port[noc_pkg::SOUTH] && up.hop_y == noc_pkg::Y_LAST))
    ) else $error("move leaves the mesh at %0t", $time);

endmodule

// ==== rtl/noc_pkg.sv ====
package noc_pkg;

    // mesh size
    localparam int NX = 4;
    localparam int NY = 4;

    // address widths, never below one bit
    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    // one-hot port indices, north is y-1 and south is y+1
    localparam int LOCAL = 0;
    localparam int EAST  = 1;
    localparam int NORTH = 2;
    localparam int WEST  = 3;
    localparam int SOUTH = 4;
    localparam int PORTS = 5;

    localparam int ENC_W = 4; // x, y, a, b

    // ab field of the encoded port
    localparam logic [1:0] AB_LOCAL = 2'b00;
    localparam logic [1:0] AB_X     = 2'b10;
    localparam logic [1:0] AB_Y     = 2'b01;

    typedef logic [XW-1:0] x_addr_t;
    typedef logic [YW-1:0] y_addr_t;

    // last router address on each axis
    localparam x_addr_t X_LAST = x_addr_t'(NX - 1);
    localparam y_addr_t Y_LAST = y_addr_t'(NY - 1);

    // x: 1 east, 0 west; y: 1 north, 0 south
    typedef struct packed {
        logic x;
        logic y;
        logic a;
        logic b;
    } port_enc_t;

    typedef logic [PORTS-1:0] port_onehot_t;

endpackage

// ==== rtl/xy_lookahead_router.sv ====
`timescale 1ns/1ps

module xy_lookahead_router (
    input  logic               clk,
    input  logic               reset,
    hop_if.dst                 up,
    output logic               out_valid,
    output noc_pkg::port_enc_t out_port
);

    logic [noc_pkg::ENC_W-1:0] route_code;

    // XY at the neighbour: finish x first, then y
    always_comb begin
        route_code = {1'b0, 1'b0, noc_pkg::AB_LOCAL};
        if (up.dest_x != up.hop_x) begin
            route_code = {up.dest_x > up.hop_x, 1'b0, noc_pkg::AB_X};     // x=1 east
        end else if (up.dest_y != up.hop_y) begin
            route_code = {1'b0, up.dest_y < up.hop_y, noc_pkg::AB_Y};     // y=1 north
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        out_port <= route_code;
    end

    a_out_ab_legal: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> !(out_port.a && out_port.b)
    ) else $error("out_port with ab = 11 at %0t", $time);

    // arrival side of the predictor:
    // the neighbour cannot sit on the edge it was entered from
    a_arrival_side: assert property (
        @(posedge clk) disable iff (reset)
        up.valid |-> !((up.hop_port[noc_pkg::EAST]  && up.hop_x == '0) ||
                       (up.hop_port[noc_pkg::NORTH] && up.hop_y == noc_pkg::Y_LAST) ||
                       (up.hop_port[noc_pkg::WEST]  && up.hop_x == noc_pkg::X_LAST) ||
                       (up.hop_port[noc_pkg::SOUTH] && up.hop_y == '0))
    ) else $error("neighbour address inconsistent with hop_port at %0t", $time);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the look-ahead routing testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
    --top-module tb_lookahead_routing \
    -f filelist.f \
    -o sim_lookahead

status=0
./obj_dir/sim_lookahead > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
exit 0

// ==== test/tb_lookahead_routing.sv ====
`timescale 1ns/1ps

module tb_lookahead_routing;

    localparam logic [3:0] P_LOCAL = 4'b0000;
    localparam logic [3:0] P_EAST  = 4'b1010; // x=1 ab=10
    localparam logic [3:0] P_WEST  = 4'b0010;
    localparam logic [3:0] P_NORTH = 4'b0101; // y=1 ab=01
    localparam logic [3:0] P_SOUTH = 4'b0001;
    localparam int NROWS       = 16;
    localparam int DRAIN_LIMIT = 20;
    localparam int NRANDOM     = 200;

    typedef struct packed {
        logic [1:0] cx;
        logic [1:0] cy;
        logic [1:0] dx;
        logic [1:0] dy;
        logic [3:0] port;
        logic [3:0] want;
    } row_t;

    // cur x/y, dest x/y, in_port, expected out_port
    row_t rows [NROWS] = '{
        '{2'd1, 2'd1, 2'd3, 2'd2, P_LOCAL, P_EAST},
        '{2'd2, 2'd1, 2'd0, 2'd3, P_LOCAL, P_WEST},
        '{2'd2, 2'd2, 2'd2, 2'd0, P_LOCAL, P_NORTH},
        '{2'd1, 2'd1, 2'd1, 2'd3, P_LOCAL, P_SOUTH},
        '{2'd2, 2'd3, 2'd2, 2'd3, P_LOCAL, P_LOCAL},
        '{2'd0, 2'd0, 2'd3, 2'd3, P_EAST,  P_EAST},
        '{2'd1, 2'd2, 2'd1, 2'd0, P_NORTH, P_NORTH},
        '{2'd3, 2'd1, 2'd0, 2'd2, P_WEST,  P_WEST},
        '{2'd2, 2'd0, 2'd2, 2'd3, P_SOUTH, P_SOUTH},
        '{2'd1, 2'd1, 2'd2, 2'd1, P_EAST,  P_LOCAL}, // neighbour is the destination
        '{2'd3, 2'd3, 2'd3, 2'd2, P_NORTH, P_LOCAL},
        '{2'd2, 2'd2, 2'd1, 2'd2, P_WEST,  P_LOCAL},
        '{2'd0, 2'd1, 2'd0, 2'd2, P_SOUTH, P_LOCAL},
        '{2'd1, 2'd0, 2'd0, 2'd3, P_SOUTH, P_WEST},
        '{2'd3, 2'd2, 2'd3, 2'd3, P_WEST,  P_EAST},
        '{2'd0, 2'd3, 2'd3, 2'd0, P_NORTH, P_EAST}
    };

    logic               clk;
    logic               reset;
    logic               in_valid;
    noc_pkg::x_addr_t   cur_x;
    noc_pkg::y_addr_t   cur_y;
    noc_pkg::x_addr_t   dest_x;
    noc_pkg::y_addr_t   dest_y;
    noc_pkg::port_enc_t in_port;
    logic               out_valid;
    noc_pkg::port_enc_t out_port;
    logic [3:0]         exp_port;  // travels with the request

    logic [3:0] exp_q [$];
    int         due_q [$];
    int         neg_cycle = 0;
    int         errors    = 0;
    int         timeouts  = 0;

    lookahead_routing_top uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .in_port   (in_port),
        .out_valid (out_valid),
        .out_port  (out_port)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // step to the neighbour on the port and route x before y
    function automatic logic [3:0] model_port(input logic [1:0] cx, cy, dx, dy,
                                              input logic [3:0] p);
        int hx;
        int hy;
        int tx;
        int ty;
        hx = int'(cx);
        hy = int'(cy);
        tx = int'(dx);
        ty = int'(dy);
        if (p == P_EAST) hx = hx + 1;
        else if (p == P_WEST) hx = hx - 1;
        else if (p == P_NORTH) hy = hy - 1; // north is y-1
        else if (p == P_SOUTH) hy = hy + 1;
        if (tx > hx) return P_EAST;
        if (tx < hx) return P_WEST;
        if (ty < hy) return P_NORTH;
        if (ty > hy) return P_SOUTH;
        return P_LOCAL;
    endfunction

    // only ports that keep the packet inside the 4x4 mesh
    function automatic logic [3:0] random_legal_port(input logic [1:0] cx, cy);
        logic [3:0] cand [5];
        int n;
        int k;
        cand = '{P_LOCAL, P_LOCAL, P_LOCAL, P_LOCAL, P_LOCAL};
        n = 1;
        if (cx != 2'd3) begin
            cand[n] = P_EAST;
            n++;
        end
        if (cx != 2'd0) begin
            cand[n] = P_WEST;
            n++;
        end
        if (cy != 2'd0) begin
            cand[n] = P_NORTH;
            n++;
        end
        if (cy != 2'd3) begin
            cand[n] = P_SOUTH;
            n++;
        end
        k = $urandom_range(n - 1, 0);
        return cand[k];
    endfunction

    task automatic send(input logic [1:0] cx, cy, dx, dy, input logic [3:0] p, want);
        @(posedge clk);
        in_valid <= 1'b1;
        cur_x    <= cx;
        cur_y    <= cy;
        dest_x   <= dx;
        dest_y   <= dy;
        in_port  <= p;
        exp_port <= want;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            timeouts++;
            $display("timeout: %0d results never came out within %0d cycles",
                     exp_q.size(), DRAIN_LIMIT);
            exp_q.delete();
            due_q.delete();
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin : monitor
        logic [3:0] want;
        int due;
        neg_cycle = neg_cycle + 1;
        if (out_valid !== 1'b0) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("FAILED at %0t: out_valid high with no request pending", $time);
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                assert (out_port === want) else begin
                    errors++;
                    $display("FAILED at %0t: out_port %b, expected %b", $time, out_port, want);
                end
                assert (neg_cycle == due) else begin
                    errors++;
                    $display("FAILED at %0t: result after %0d cycles, expected 3",
                             $time, neg_cycle - due + 3);
                end
            end
        end
        if (reset === 1'b0 && in_valid === 1'b1) begin
            exp_q.push_back(exp_port);
            due_q.push_back(neg_cycle + 3); // three registered stages
        end
    end

    initial begin : stimulus
        int gap;
        logic [1:0] cx;
        logic [1:0] cy;
        logic [1:0] dx;
        logic [1:0] dy;
        logic [3:0] p;
        void'($urandom(32'h8904));
        reset    = 1'b1;
        in_valid = 1'b0;
        cur_x    = '0;
        cur_y    = '0;
        dest_x   = '0;
        dest_y   = '0;
        in_port  = '0;
        exp_port = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        idle(4); // out_valid must stay low here

        for (int i = 0; i < NROWS; i++) begin
            assert (model_port(rows[i].cx, rows[i].cy, rows[i].dx, rows[i].dy,
                               rows[i].port) == rows[i].want) else begin
                errors++;
                $display("table row %0d does not agree with the routing model", i);
            end
            send(rows[i].cx, rows[i].cy, rows[i].dx, rows[i].dy, rows[i].port, rows[i].want);
            idle(4);
        end
        wait_drain();

        // same rows back to back with three in flight
        for (int i = 0; i < NROWS; i++) begin
            send(rows[i].cx, rows[i].cy, rows[i].dx, rows[i].dy, rows[i].port, rows[i].want);
        end
        idle(1);
        wait_drain();

        for (int n = 0; n < NRANDOM; n++) begin
            cx = 2'($urandom_range(3, 0));
            cy = 2'($urandom_range(3, 0));
            dx = 2'($urandom_range(3, 0));
            dy = 2'($urandom_range(3, 0));
            p  = random_legal_port(cx, cy);
            send(cx, cy, dx, dy, p, model_port(cx, cy, dx, dy, p));
            gap = $urandom_range(3, 0);
            if (gap > 0) idle(gap);
        end
        idle(1);
        wait_drain();

        $display("%0d mismatches, %0d timeouts, %0d results pending",
                 errors, timeouts, exp_q.size());
        if (errors == 0 && timeouts == 0 && exp_q.size() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
